// File: verilog/tile_config.svh
// widths, region layout and control register reset values for the tile endpoint
// all addresses are word addresses; region bits are absolute positions in them
// every value here is fixed for the whole mesh, none varies per tile
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// datapath
`define TILE_DATA_WIDTH 32
`define TILE_MASK_WIDTH 4
`define TILE_ADDR_WIDTH 16

// data memory region 0x400-0x7ff
`define TILE_DMEM_ADDR_WIDTH 10

// instruction cache region 0x1000-0x1fff, pc is tag over index
`define TILE_ICACHE_INDEX_WIDTH 10
`define TILE_ICACHE_TAG_WIDTH 2
`define TILE_PC_WIDTH 12

// control registers 0x80-0xff, indices 0..4 are mapped
`define TILE_CSR_ADDR_WIDTH 8
`define TILE_X_WIDTH 4
`define TILE_Y_WIDTH 4

`define TILE_FREEZE_RESET 1
`define TILE_TGO_X_RESET 0
`define TILE_TGO_Y_RESET 1
`define TILE_PC_INIT_RESET 0
`define TILE_DRAM_ENABLE_RESET 1

`define TILE_INVALID_RESPONSE 32'hdead_beef

`endif

// File: verilog/tile_pkg.sv
// types shared by the endpoint blocks
// epa_addr_u overlays the data memory and control register decodes on one address
`default_nettype none

`include "tile_config.svh"

package tile_pkg;

  // part_sel picks the byte; bit 1 of it picks the halfword
  typedef struct packed {
    logic       is_unsigned_op;
    logic       is_byte_op;
    logic       is_hex_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef union packed {
    struct packed {
      logic [`TILE_ADDR_WIDTH-`TILE_DMEM_ADDR_WIDTH-2:0] high;
      logic                                             region;
      logic [`TILE_DMEM_ADDR_WIDTH-1:0]                 index;
    } dmem_view;
    // register index lives in the low bits below the region bit
    struct packed {
      logic [`TILE_ADDR_WIDTH-`TILE_CSR_ADDR_WIDTH-1:0] high;
      logic                                            region;
      logic [`TILE_CSR_ADDR_WIDTH-2:0]                 index;
    } csr_view;
  } epa_addr_u;

endpackage

`default_nettype wire

// File: verilog/load_packer.sv
// shapes a data memory word into the value a load returns
// byte and halfword loads are sign or zero extended, word loads pass through
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module load_packer (
  input  wire logic [`TILE_DATA_WIDTH-1:0] mem_data_i,
  input  wire tile_pkg::load_info_s        load_info_i,
  output logic [`TILE_DATA_WIDTH-1:0]      load_data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        byte_sign;
  logic        half_sign;

  assign byte_sel = mem_data_i[8*load_info_i.part_sel +: 8];
  assign half_sel = mem_data_i[16*load_info_i.part_sel[1] +: 16];

  // fill bit is zero for unsigned loads
  assign byte_sign = ~load_info_i.is_unsigned_op & byte_sel[7];
  assign half_sign = ~load_info_i.is_unsigned_op & half_sel[15];

  always_comb begin
    if (load_info_i.is_byte_op) begin
      load_data_o = {{(`TILE_DATA_WIDTH-8){byte_sign}}, byte_sel};
    end else if (load_info_i.is_hex_op) begin
      load_data_o = {{(`TILE_DATA_WIDTH-16){half_sign}}, half_sel};
    end else begin
      load_data_o = mem_data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/remote_dmem.sv
// tile data memory shared by the local core and the network
// the core port always wins, a remote access waits until the core is idle
// reads are registered per port, a write lands on the accepting edge
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module remote_dmem (
  input  wire logic                             clk_i,
  input  wire logic                             reset_i,
  input  wire logic                             core_v_i,
  input  wire logic                             core_w_i,
  input  wire logic [`TILE_DMEM_ADDR_WIDTH-1:0] core_addr_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]      core_data_i,
  input  wire logic [`TILE_MASK_WIDTH-1:0]      core_mask_i,
  input  wire logic                             remote_v_i,
  input  wire logic                             remote_w_i,
  input  wire logic [`TILE_DMEM_ADDR_WIDTH-1:0] remote_addr_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]      remote_data_i,
  input  wire logic [`TILE_MASK_WIDTH-1:0]      remote_mask_i,
  output logic [`TILE_DATA_WIDTH-1:0]           core_rdata_o,
  output logic                                  remote_yumi_o,
  output logic [`TILE_DATA_WIDTH-1:0]           remote_rdata_o
);

  logic [`TILE_DATA_WIDTH-1:0] mem [1 << `TILE_DMEM_ADDR_WIDTH];

  logic                             wr_en;
  logic [`TILE_DMEM_ADDR_WIDTH-1:0] wr_addr;
  logic [`TILE_DATA_WIDTH-1:0]      wr_data;
  logic [`TILE_MASK_WIDTH-1:0]      wr_mask;

  assign remote_yumi_o = remote_v_i & ~core_v_i;

  // single write port, core first
  assign wr_en   = core_v_i ? core_w_i : (remote_v_i & remote_w_i);
  assign wr_addr = core_v_i ? core_addr_i : remote_addr_i;
  assign wr_data = core_v_i ? core_data_i : remote_data_i;
  assign wr_mask = core_v_i ? core_mask_i : remote_mask_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < `TILE_MASK_WIDTH; i++) begin
        if (wr_mask[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      core_rdata_o   <= '0;
      remote_rdata_o <= '0;
    end else begin
      if (core_v_i & ~core_w_i) begin
        core_rdata_o <= mem[core_addr_i];
      end
      if (remote_yumi_o & ~remote_w_i) begin
        remote_rdata_o <= mem[remote_addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/icache_mem.sv
// instruction store filled over the network and fetched by the local core
// a fetch blocks a remote write in the same cycle
// valid bits clear on reset, instructions and tags do not
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module icache_mem (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic                         write_v_i,
  input  wire logic [`TILE_PC_WIDTH-1:0]    write_pc_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]  write_instr_i,
  input  wire logic                         fetch_v_i,
  input  wire logic [`TILE_PC_WIDTH-1:0]    fetch_pc_i,
  output logic                              write_yumi_o,
  output logic [`TILE_DATA_WIDTH-1:0]       fetch_instr_o,
  output logic                              fetch_hit_o
);

  localparam int unsigned ENTRIES = 1 << `TILE_ICACHE_INDEX_WIDTH;

  logic [`TILE_DATA_WIDTH-1:0]      instr_mem [ENTRIES];
  logic [`TILE_ICACHE_TAG_WIDTH-1:0] tag_mem  [ENTRIES];
  logic [ENTRIES-1:0]                valid_r;

  logic [`TILE_ICACHE_INDEX_WIDTH-1:0] wr_idx;
  logic [`TILE_ICACHE_INDEX_WIDTH-1:0] rd_idx;

  assign write_yumi_o = write_v_i & ~fetch_v_i;

  assign wr_idx = write_pc_i[`TILE_ICACHE_INDEX_WIDTH-1:0];
  assign rd_idx = fetch_pc_i[`TILE_ICACHE_INDEX_WIDTH-1:0];

  always_ff @(posedge clk_i) begin
    if (write_yumi_o) begin
      instr_mem[wr_idx] <= write_instr_i;
      tag_mem[wr_idx]   <= write_pc_i[`TILE_PC_WIDTH-1:`TILE_ICACHE_INDEX_WIDTH];
    end
    if (fetch_v_i) begin
      fetch_instr_o <= instr_mem[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r     <= '0;
      fetch_hit_o <= 1'b0;
    end else begin
      if (write_yumi_o) begin
        valid_r[wr_idx] <= 1'b1;
      end
      if (fetch_v_i) begin
        fetch_hit_o <= valid_r[rd_idx]
          & (tag_mem[rd_idx] == fetch_pc_i[`TILE_PC_WIDTH-1:`TILE_ICACHE_INDEX_WIDTH]);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/network_rx.sv
// receive side of the tile endpoint
// decodes a request into data memory, instruction cache or control registers,
// accepts it once the target can take it and answers one cycle later
// cache reads and unmapped addresses are accepted and answered with the invalid word
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module network_rx (
  input  wire logic                             clk_i,
  input  wire logic                             reset_i,
  input  wire logic                             v_i,
  input  wire logic                             w_i,
  input  wire logic [`TILE_ADDR_WIDTH-1:0]      addr_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]      data_i,
  input  wire logic [`TILE_MASK_WIDTH-1:0]      mask_i,
  input  wire tile_pkg::load_info_s             load_info_i,
  input  wire logic                             remote_dmem_yumi_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]      remote_dmem_data_i,
  input  wire logic                             icache_yumi_i,
  output logic                                  yumi_o,
  output logic                                  returning_data_v_o,
  output logic [`TILE_DATA_WIDTH-1:0]           returning_data_o,
  output logic                                  remote_dmem_v_o,
  output logic                                  remote_dmem_w_o,
  output logic [`TILE_DMEM_ADDR_WIDTH-1:0]      remote_dmem_addr_o,
  output logic [`TILE_MASK_WIDTH-1:0]           remote_dmem_mask_o,
  output logic [`TILE_DATA_WIDTH-1:0]           remote_dmem_data_o,
  output logic                                  icache_v_o,
  output logic [`TILE_PC_WIDTH-1:0]             icache_pc_o,
  output logic [`TILE_DATA_WIDTH-1:0]           icache_instr_o,
  output logic                                  freeze_o,
  output logic [`TILE_X_WIDTH-1:0]              tgo_x_o,
  output logic [`TILE_Y_WIDTH-1:0]              tgo_y_o,
  output logic [`TILE_PC_WIDTH-1:0]             pc_init_val_o,
  output logic                                  dram_enable_o
);

  import tile_pkg::*;

  epa_addr_u addr_u;

  logic is_dmem;
  logic is_icache;
  logic is_csr;
  logic csr_valid;
  logic accept;

  // owed response, one cycle deep
  logic       send_dmem_r;
  logic       send_csr_r;
  logic       send_zero_r;
  logic       send_invalid_r;
  logic [2:0] csr_sel_r;
  load_info_s load_info_r;

  logic [`TILE_DATA_WIDTH-1:0] load_data;

  assign addr_u = addr_i;

  assign is_dmem = addr_u.dmem_view.region & (addr_u.dmem_view.high == '0);
  assign is_icache = addr_i[`TILE_PC_WIDTH]
    & (addr_i[`TILE_ADDR_WIDTH-1:`TILE_PC_WIDTH+1] == '0);
  assign is_csr = addr_u.csr_view.region & (addr_u.csr_view.high == '0);
  assign csr_valid = is_csr & (addr_u.csr_view.index < 7'd5);

  // memories only accept while the request is valid
  always_comb begin
    remote_dmem_v_o = 1'b0;
    icache_v_o      = 1'b0;
    if (is_dmem) begin
      remote_dmem_v_o = v_i;
      yumi_o          = remote_dmem_yumi_i;
    end else if (is_icache & w_i) begin
      icache_v_o = v_i;
      yumi_o     = icache_yumi_i;
    end else begin
      yumi_o = v_i;
    end
  end

  assign accept = v_i & yumi_o;

  assign remote_dmem_w_o    = w_i;
  assign remote_dmem_addr_o = addr_u.dmem_view.index;
  assign remote_dmem_mask_o = mask_i;
  assign remote_dmem_data_o = data_i;
  assign icache_pc_o        = addr_i[`TILE_PC_WIDTH-1:0];
  assign icache_instr_o     = data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      freeze_o       <= 1'(`TILE_FREEZE_RESET);
      tgo_x_o        <= `TILE_X_WIDTH'(`TILE_TGO_X_RESET);
      tgo_y_o        <= `TILE_Y_WIDTH'(`TILE_TGO_Y_RESET);
      pc_init_val_o  <= `TILE_PC_WIDTH'(`TILE_PC_INIT_RESET);
      dram_enable_o  <= 1'(`TILE_DRAM_ENABLE_RESET);
      send_dmem_r    <= 1'b0;
      send_csr_r     <= 1'b0;
      send_zero_r    <= 1'b0;
      send_invalid_r <= 1'b0;
    end else begin
      if (accept & w_i & csr_valid) begin
        case (addr_u.csr_view.index[2:0])
          3'd0: freeze_o <= data_i[0];
          3'd1: tgo_x_o <= data_i[`TILE_X_WIDTH-1:0];
          3'd2: tgo_y_o <= data_i[`TILE_Y_WIDTH-1:0];
          // word-aligned pc, low two bits dropped
          3'd3: pc_init_val_o <= data_i[2 +: `TILE_PC_WIDTH];
          default: dram_enable_o <= data_i[0];
        endcase
      end
      send_dmem_r    <= accept & ~w_i & is_dmem;
      send_csr_r     <= accept & ~w_i & csr_valid;
      send_zero_r    <= accept & w_i & (is_dmem | is_icache | csr_valid);
      send_invalid_r <= accept & ~(is_dmem | (is_icache & w_i) | csr_valid);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      load_info_r <= load_info_i;
      csr_sel_r   <= addr_u.csr_view.index[2:0];
    end
  end

  load_packer i_load_packer (
    .mem_data_i  (remote_dmem_data_i),
    .load_info_i (load_info_r),
    .load_data_o (load_data)
  );

  assign returning_data_v_o = send_dmem_r | send_csr_r | send_zero_r | send_invalid_r;

  always_comb begin
    returning_data_o = '0;
    if (send_dmem_r) begin
      returning_data_o = load_data;
    end else if (send_invalid_r) begin
      returning_data_o = `TILE_INVALID_RESPONSE;
    end else if (send_csr_r) begin
      case (csr_sel_r)
        3'd0: returning_data_o = `TILE_DATA_WIDTH'(freeze_o);
        3'd1: returning_data_o = `TILE_DATA_WIDTH'(tgo_x_o);
        3'd2: returning_data_o = `TILE_DATA_WIDTH'(tgo_y_o);
        3'd3: returning_data_o = `TILE_DATA_WIDTH'({pc_init_val_o, 2'b00});
        default: returning_data_o = `TILE_DATA_WIDTH'(dram_enable_o);
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/tile_endpoint_top.sv
// remote-request endpoint of one tile
// network requests use valid/yumi, responses are a one-cycle strobe with no back-pressure
// the local core and fetch ports take priority over the network
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tile_endpoint_top (
  input  wire logic                             clk_i,
  input  wire logic                             reset_i,
  input  wire logic                             req_v_i,
  input  wire logic                             req_w_i,
  input  wire logic [`TILE_ADDR_WIDTH-1:0]      req_addr_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]      req_data_i,
  input  wire logic [`TILE_MASK_WIDTH-1:0]      req_mask_i,
  input  wire tile_pkg::load_info_s             req_load_info_i,
  input  wire logic                             core_v_i,
  input  wire logic                             core_w_i,
  input  wire logic [`TILE_DMEM_ADDR_WIDTH-1:0] core_addr_i,
  input  wire logic [`TILE_DATA_WIDTH-1:0]      core_data_i,
  input  wire logic [`TILE_MASK_WIDTH-1:0]      core_mask_i,
  input  wire logic                             fetch_v_i,
  input  wire logic [`TILE_PC_WIDTH-1:0]        fetch_pc_i,
  output logic                                  req_yumi_o,
  output logic                                  resp_v_o,
  output logic [`TILE_DATA_WIDTH-1:0]           resp_data_o,
  output logic [`TILE_DATA_WIDTH-1:0]           core_rdata_o,
  output logic [`TILE_DATA_WIDTH-1:0]           fetch_instr_o,
  output logic                                  fetch_hit_o,
  output logic                                  freeze_o,
  output logic [`TILE_X_WIDTH-1:0]              tgo_x_o,
  output logic [`TILE_Y_WIDTH-1:0]              tgo_y_o,
  output logic [`TILE_PC_WIDTH-1:0]             pc_init_val_o,
  output logic                                  dram_enable_o
);

  logic                             remote_v;
  logic                             remote_w;
  logic [`TILE_DMEM_ADDR_WIDTH-1:0] remote_addr;
  logic [`TILE_DATA_WIDTH-1:0]      remote_data;
  logic [`TILE_MASK_WIDTH-1:0]      remote_mask;
  logic                             remote_yumi;
  logic [`TILE_DATA_WIDTH-1:0]      remote_rdata;

  logic                             icache_v;
  logic [`TILE_PC_WIDTH-1:0]        icache_pc;
  logic [`TILE_DATA_WIDTH-1:0]      icache_instr;
  logic                             icache_yumi;

  network_rx i_network_rx (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .v_i                (req_v_i),
    .w_i                (req_w_i),
    .addr_i             (req_addr_i),
    .data_i             (req_data_i),
    .mask_i             (req_mask_i),
    .load_info_i        (req_load_info_i),
    .remote_dmem_yumi_i (remote_yumi),
    .remote_dmem_data_i (remote_rdata),
    .icache_yumi_i      (icache_yumi),
    .yumi_o             (req_yumi_o),
    .returning_data_v_o (resp_v_o),
    .returning_data_o   (resp_data_o),
    .remote_dmem_v_o    (remote_v),
    .remote_dmem_w_o    (remote_w),
    .remote_dmem_addr_o (remote_addr),
    .remote_dmem_mask_o (remote_mask),
    .remote_dmem_data_o (remote_data),
    .icache_v_o         (icache_v),
    .icache_pc_o        (icache_pc),
    .icache_instr_o     (icache_instr),
    .freeze_o           (freeze_o),
    .tgo_x_o            (tgo_x_o),
    .tgo_y_o            (tgo_y_o),
    .pc_init_val_o      (pc_init_val_o),
    .dram_enable_o      (dram_enable_o)
  );

  remote_dmem i_remote_dmem (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .core_v_i       (core_v_i),
    .core_w_i       (core_w_i),
    .core_addr_i    (core_addr_i),
    .core_data_i    (core_data_i),
    .core_mask_i    (core_mask_i),
    .remote_v_i     (remote_v),
    .remote_w_i     (remote_w),
    .remote_addr_i  (remote_addr),
    .remote_data_i  (remote_data),
    .remote_mask_i  (remote_mask),
    .core_rdata_o   (core_rdata_o),
    .remote_yumi_o  (remote_yumi),
    .remote_rdata_o (remote_rdata)
  );

  icache_mem i_icache_mem (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .write_v_i     (icache_v),
    .write_pc_i    (icache_pc),
    .write_instr_i (icache_instr),
    .fetch_v_i     (fetch_v_i),
    .fetch_pc_i    (fetch_pc_i),
    .write_yumi_o  (icache_yumi),
    .fetch_instr_o (fetch_instr_o),
    .fetch_hit_o   (fetch_hit_o)
  );

endmodule

`default_nettype wire

// File: verification/tile_endpoint_assertions.sv
// handshake and response timing checks for the tile endpoint
// sampled on the falling clock, where requests and responses are settled
// assumes requests are held stable from one rising edge to the next
`timescale 1ns/1ps
`default_nettype none

module tile_endpoint_assertions (
  input wire logic clk_i,
  input wire logic reset_i,
  input wire logic req_v_i,
  input wire logic req_yumi_i,
  input wire logic resp_v_i
);

  int unsigned yumi_failures = 0;
  int unsigned resp_failures = 0;
  int unsigned reset_failures = 0;

  // yumi only answers a valid request
  yumi_needs_valid: assert property (@(negedge clk_i) req_yumi_i |-> req_v_i)
    else begin
      $error("req_yumi_o high while req_v_i is low");
      yumi_failures++;
    end

  // strobe exactly one cycle after each acceptance
  resp_one_cycle: assert property (@(negedge clk_i) disable iff (reset_i)
    resp_v_i == $past(req_v_i && req_yumi_i))
    else begin
      $error("resp_v_o not one cycle after an acceptance");
      resp_failures++;
    end

  resp_quiet_in_reset: assert property (@(negedge clk_i) reset_i |-> !resp_v_i)
    else begin
      $error("resp_v_o high during reset");
      reset_failures++;
    end

endmodule

bind tile_endpoint_top tile_endpoint_assertions i_tile_endpoint_assertions (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_v_i    (req_v_i),
  .req_yumi_i (req_yumi_o),
  .resp_v_i   (resp_v_o)
);

`default_nettype wire

// File: verification/tile_endpoint_tb.sv
// testbench for the tile endpoint
// every data memory word is written in full before it is loaded
// expects exactly one response per accepted request, one cycle after acceptance
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tile_endpoint_tb;

  import tile_pkg::*;

  localparam int TIMEOUT = 20;
  // unmapped words, then register indices past dram_enable
  localparam logic [15:0] BAD_ADDRS [8] = '{16'h0000, 16'h0300, 16'h0800, 16'h2000,
                                            16'hffff, 16'h0085, 16'h0086, 16'h00ff};

  logic                             clk_i = 1'b0;
  logic                             reset_i = 1'b1;
  logic                             req_v_i = 1'b0;
  logic                             req_w_i = 1'b0;
  logic [`TILE_ADDR_WIDTH-1:0]      req_addr_i = '0;
  logic [`TILE_DATA_WIDTH-1:0]      req_data_i = '0;
  logic [`TILE_MASK_WIDTH-1:0]      req_mask_i = '0;
  load_info_s                       req_load_info_i = '0;
  logic                             core_v_i = 1'b0;
  logic                             core_w_i = 1'b0;
  logic [`TILE_DMEM_ADDR_WIDTH-1:0] core_addr_i = '0;
  logic [`TILE_DATA_WIDTH-1:0]      core_data_i = '0;
  logic [`TILE_MASK_WIDTH-1:0]      core_mask_i = '0;
  logic                             fetch_v_i = 1'b0;
  logic [`TILE_PC_WIDTH-1:0]        fetch_pc_i = '0;

  logic                             req_yumi_o;
  logic                             resp_v_o;
  logic [`TILE_DATA_WIDTH-1:0]      resp_data_o;
  logic [`TILE_DATA_WIDTH-1:0]      core_rdata_o;
  logic [`TILE_DATA_WIDTH-1:0]      fetch_instr_o;
  logic                             fetch_hit_o;
  logic                             freeze_o;
  logic [`TILE_X_WIDTH-1:0]         tgo_x_o;
  logic [`TILE_Y_WIDTH-1:0]         tgo_y_o;
  logic [`TILE_PC_WIDTH-1:0]        pc_init_val_o;
  logic                             dram_enable_o;

  integer      seed = 45119;
  int unsigned errors = 0;
  logic [31:0] ref_mem [1 << `TILE_DMEM_ADDR_WIDTH];
  // register values as a read returns them
  logic [31:0] csr_model [5];
  logic [31:0] expected_q [$];
  logic [31:0] resp_expected;

  always #5 clk_i = ~clk_i;

  tile_endpoint_top i_tile_endpoint_top (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_v_i         (req_v_i),
    .req_w_i         (req_w_i),
    .req_addr_i      (req_addr_i),
    .req_data_i      (req_data_i),
    .req_mask_i      (req_mask_i),
    .req_load_info_i (req_load_info_i),
    .core_v_i        (core_v_i),
    .core_w_i        (core_w_i),
    .core_addr_i     (core_addr_i),
    .core_data_i     (core_data_i),
    .core_mask_i     (core_mask_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_pc_i      (fetch_pc_i),
    .req_yumi_o      (req_yumi_o),
    .resp_v_o        (resp_v_o),
    .resp_data_o     (resp_data_o),
    .core_rdata_o    (core_rdata_o),
    .fetch_instr_o   (fetch_instr_o),
    .fetch_hit_o     (fetch_hit_o),
    .freeze_o        (freeze_o),
    .tgo_x_o         (tgo_x_o),
    .tgo_y_o         (tgo_y_o),
    .pc_init_val_o   (pc_init_val_o),
    .dram_enable_o   (dram_enable_o)
  );

  function automatic logic [15:0] dmem_addr(logic [9:0] idx);
    return {5'd0, 1'b1, idx};
  endfunction

  function automatic logic [15:0] csr_addr(logic [6:0] idx);
    return {8'd0, 1'b1, idx};
  endfunction

  function automatic logic [15:0] icache_addr(logic [11:0] pc);
    return {3'd0, 1'b1, pc};
  endfunction

  function automatic logic [31:0] apply_mask(logic [31:0] old_word, logic [31:0] data,
                                             logic [3:0] mask);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [31:0] expect_load(logic [31:0] word, load_info_s info);
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    case (info.part_sel)
      2'd0: sel_byte = word[7:0];
      2'd1: sel_byte = word[15:8];
      2'd2: sel_byte = word[23:16];
      default: sel_byte = word[31:24];
    endcase
    sel_half = info.part_sel[1] ? word[31:16] : word[15:0];
    if (info.is_byte_op) begin
      return info.is_unsigned_op ? {24'd0, sel_byte} : {{24{sel_byte[7]}}, sel_byte};
    end
    if (info.is_hex_op) begin
      return info.is_unsigned_op ? {16'd0, sel_half} : {{16{sel_half[15]}}, sel_half};
    end
    return word;
  endfunction

  function automatic load_info_s make_info(logic is_unsigned, logic is_byte, logic is_half,
                                           logic [1:0] part);
    load_info_s info;
    info.is_unsigned_op = is_unsigned;
    info.is_byte_op     = is_byte;
    info.is_hex_op      = is_half;
    info.part_sel       = part;
    return info;
  endfunction

  // read-back value of a register after a write of data
  function automatic logic [31:0] csr_written(int idx, logic [31:0] data);
    case (idx)
      0, 4: return {31'd0, data[0]};
      1, 2: return {28'd0, data[3:0]};
      default: return {18'd0, data[13:2], 2'b00};
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    assert (got === expected) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, expected);
    end
  endtask

  task automatic check_csr_outputs();
    check_value("freeze_o", 32'(freeze_o), csr_model[0]);
    check_value("tgo_x_o", 32'(tgo_x_o), csr_model[1]);
    check_value("tgo_y_o", 32'(tgo_y_o), csr_model[2]);
    check_value("pc_init_val_o", 32'(pc_init_val_o), csr_model[3] >> 2);
    check_value("dram_enable_o", 32'(dram_enable_o), csr_model[4]);
  endtask

  task automatic drive_req(logic w, logic [15:0] addr, logic [31:0] data, logic [3:0] mask,
                           load_info_s info);
    req_v_i         = 1'b1;
    req_w_i         = w;
    req_addr_i      = addr;
    req_data_i      = data;
    req_mask_i      = mask;
    req_load_info_i = info;
  endtask

  // holds the driven request until an edge accepts it
  task automatic await_accept(logic [31:0] expected);
    logic accepted;
    int   cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!req_yumi_o && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk_i);
    end
    accepted = req_yumi_o;
    @(posedge clk_i);
    #1;
    req_v_i = 1'b0;
    if (accepted) begin
      expected_q.push_back(expected);
    end else begin
      errors++;
      $display("request to address %h was not accepted in %0d cycles", req_addr_i, TIMEOUT);
    end
  endtask

  task automatic send_req(logic w, logic [15:0] addr, logic [31:0] data, logic [3:0] mask,
                          load_info_s info, logic [31:0] expected);
    drive_req(w, addr, data, mask, info);
    await_accept(expected);
  endtask

  task automatic expect_blocked(int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value("req_yumi_o", 32'(req_yumi_o), 32'd0);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic core_read(logic [9:0] idx);
    core_v_i    = 1'b1;
    core_w_i    = 1'b0;
    core_addr_i = idx;
    @(posedge clk_i);
    #1;
    core_v_i = 1'b0;
    check_value("core_rdata_o", core_rdata_o, ref_mem[idx]);
  endtask

  task automatic fetch_check(logic [11:0] pc, logic [31:0] instr, logic hit);
    fetch_v_i  = 1'b1;
    fetch_pc_i = pc;
    @(posedge clk_i);
    #1;
    fetch_v_i = 1'b0;
    check_value("fetch_hit_o", 32'(fetch_hit_o), 32'(hit));
    if (hit) begin
      check_value("fetch_instr_o", fetch_instr_o, instr);
    end
  endtask

  // responses are settled by the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (resp_v_o && expected_q.size() == 0) begin
        errors++;
        $display("response strobe with no accepted request outstanding");
      end else if (resp_v_o) begin
        resp_expected = expected_q.pop_front();
        check_value("resp_data_o", resp_data_o, resp_expected);
      end else if (expected_q.size() != 0) begin
        errors++;
        $display("no response one cycle after an accepted request");
        expected_q.delete();
      end
    end
  end

  initial begin
    logic [9:0]  idx;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [31:0] instr;
    load_info_s  info;
    int          pos;
    int          wait_cycles;
    int unsigned assert_failures;
    csr_model[0] = 32'(`TILE_FREEZE_RESET);
    csr_model[1] = 32'(`TILE_TGO_X_RESET);
    csr_model[2] = 32'(`TILE_TGO_Y_RESET);
    csr_model[3] = 32'(`TILE_PC_INIT_RESET) << 2;
    csr_model[4] = 32'(`TILE_DRAM_ENABLE_RESET);
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // reset values
    check_csr_outputs();
    for (int r = 0; r < 5; r++) begin
      send_req(1'b0, csr_addr(7'(r)), '0, '0, '0, csr_model[r]);
    end

    // register writes, one bit forced to differ from the current value
    for (int r = 0; r < 5; r++) begin
      data = $random(seed);
      pos = (r == 3) ? 2 : 0;
      data[pos] = ~csr_model[r][pos];
      send_req(1'b1, csr_addr(7'(r)), data, 4'hf, '0, 32'd0);
      csr_model[r] = csr_written(r, data);
      check_csr_outputs();
      send_req(1'b0, csr_addr(7'(r)), '0, '0, '0, csr_model[r]);
    end

    // data memory writes and loads
    for (int i = 0; i < 6; i++) begin
      idx = 10'(i * 173 + 11);
      data = $random(seed);
      send_req(1'b1, dmem_addr(idx), data, 4'hf, '0, 32'd0);
      ref_mem[idx] = data;
      data = $random(seed);
      mask = 4'($random(seed));
      send_req(1'b1, dmem_addr(idx), data, mask, '0, 32'd0);
      ref_mem[idx] = apply_mask(ref_mem[idx], data, mask);
      core_read(idx);
      for (int u = 0; u < 2; u++) begin
        for (int p = 0; p < 4; p++) begin
          info = make_info(u[0], 1'b1, 1'b0, 2'(p));
          send_req(1'b0, dmem_addr(idx), '0, '0, info, expect_load(ref_mem[idx], info));
          info = make_info(u[0], 1'b0, 1'b1, 2'(p));
          send_req(1'b0, dmem_addr(idx), '0, '0, info, expect_load(ref_mem[idx], info));
        end
      end
      send_req(1'b0, dmem_addr(idx), '0, '0, '0, ref_mem[idx]);
    end

    // invalid accesses
    for (int k = 0; k < 8; k++) begin
      send_req(1'b1, BAD_ADDRS[k], $random(seed), 4'hf, '0, `TILE_INVALID_RESPONSE);
      send_req(1'b0, BAD_ADDRS[k], '0, '0, '0, `TILE_INVALID_RESPONSE);
    end
    send_req(1'b0, icache_addr(12'h0a5), '0, '0, '0, `TILE_INVALID_RESPONSE);
    check_csr_outputs();

    // core port holds off a remote load
    idx = 10'd11;
    core_v_i    = 1'b1;
    core_w_i    = 1'b0;
    core_addr_i = idx;
    drive_req(1'b0, dmem_addr(idx), '0, '0, '0);
    expect_blocked(4);
    core_v_i = 1'b0;
    await_accept(ref_mem[idx]);

    // fetch port holds off a cache write
    instr = $random(seed);
    fetch_v_i  = 1'b1;
    fetch_pc_i = 12'h000;
    drive_req(1'b1, icache_addr(12'h5a3), instr, 4'hf, '0);
    expect_blocked(4);
    fetch_v_i = 1'b0;
    await_accept(32'd0);
    fetch_check(12'h5a3, instr, 1'b1);

    // cache fill, then a fetch with the same index and another tag
    instr = $random(seed);
    send_req(1'b1, icache_addr(12'h9c4), instr, 4'hf, '0, 32'd0);
    fetch_check(12'h9c4, instr, 1'b1);
    fetch_check(12'h1c4, instr, 1'b0);

    wait_cycles = 0;
    while (expected_q.size() != 0 && wait_cycles < TIMEOUT) begin
      wait_cycles++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    assert_failures = i_tile_endpoint_top.i_tile_endpoint_assertions.yumi_failures
      + i_tile_endpoint_top.i_tile_endpoint_assertions.resp_failures
      + i_tile_endpoint_top.i_tile_endpoint_assertions.reset_failures;
    $display("errors: %0d from checks, %0d from assertions", errors, assert_failures);
    if (errors == 0 && assert_failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/tile_pkg.sv
verilog/load_packer.sv
verilog/remote_dmem.sv
verilog/icache_mem.sv
verilog/network_rx.sv
verilog/tile_endpoint_top.sv
verification/tile_endpoint_assertions.sv
verification/tile_endpoint_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the tile endpoint testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=tile_endpoint_sim

if ! verilator --binary --timing --assert -f sources.f --top-module tile_endpoint_tb \
    -Mdir "$build_dir" -o "$sim_bin"; then
  echo "verilator build failed"
  exit 1
fi

output=$("./$build_dir/$sim_bin" +verilator+error+limit+1000)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
